// File: Bender.yml
package:
  name: frontend

sources:
  - include_dirs:
      - src
    files:
      - src/core_pkg.sv
      - src/trap_csr.sv
      - src/flush_ctrl.sv
      - src/pc_gen.sv
      - src/fetch_unit.sv
      - src/frontend_top.sv
  - target: test
    include_dirs:
      - src
      - verification
    files:
      - verification/tb_frontend.sv

// File: all.f
+incdir+src
+incdir+verification
src/core_pkg.sv
src/trap_csr.sv
src/flush_ctrl.sv
src/pc_gen.sv
src/fetch_unit.sv
src/frontend_top.sv
verification/tb_frontend.sv

// File: src/core_macros.svh
// Widths, CSR addresses and reset values for the instruction front end
// Only machine-mode trap CSRs are implemented; other CSR addresses read 0
// One 64-bit word is fetched per request, so the PC steps by 8 bytes
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath widths
`define XLEN            64
`define ADDR_W          64
`define CSR_ADDR_W      12

// Machine CSR addresses
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341

// Byte step per fetched word
`define PC_STEP         8

// Trap vector after reset
`define TRAP_VEC_RESET  64'h100

`endif

// File: src/core_pkg.sv
// Shared types of the instruction front end
// Widths come from core_macros.svh
// redirect_e lists the redirect causes; REDIR_NONE means the PC advances normally
`default_nettype none

`include "core_macros.svh"

package core_pkg;

    // Vectors with a fixed meaning
    typedef logic [`ADDR_W-1:0]     addr_t;
    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // ----------------------------------------
    // Redirect cause, listed by priority
    // ----------------------------------------
    typedef enum logic [2:0] {
        REDIR_NONE,
        REDIR_DEBUG,
        REDIR_TRAP,
        REDIR_ERET,
        REDIR_BRANCH
    } redirect_e;

    // ----------------------------------------
    // Fetch unit request FSM
    // ----------------------------------------
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT_GNT,
        FETCH_WAIT_RVALID
    } fetch_state_e;

endpackage

`default_nettype wire

// File: src/fetch_unit.sv
// Instruction memory request FSM with a single output entry
// One request outstanding at a time; req and addr are held until the grant
// A flush while a request is in flight marks it killed: its answer is dropped
// and it does not advance the PC; the held output entry is cleared as well
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import core_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  enable_i,
    input  logic  flush_i,
    input  addr_t fetch_pc_i,
    output logic  advance_o,
    // Instruction memory port
    output logic  instr_req_o,
    output addr_t instr_addr_o,
    input  logic  instr_gnt_i,
    input  logic  instr_rvalid_i,
    input  word_t instr_rdata_i,
    // Fetch output
    output logic  fetch_valid_o,
    output addr_t fetch_addr_o,
    output word_t fetch_rdata_o,
    input  logic  fetch_ready_i
);

    fetch_state_e state_q, state_d;
    logic         killed_q, killed_d;
    logic         out_free;
    logic         fill;
    addr_t        req_addr_q;

    // Output entry
    logic         out_valid_q;
    addr_t        out_addr_q;
    word_t        out_rdata_q;

    // Free now, or being taken at this edge
    assign out_free = !out_valid_q || fetch_ready_i;

    // ----------------------------------------
    // Request FSM
    // ----------------------------------------
    always_comb begin
        state_d      = state_q;
        killed_d     = killed_q;
        instr_req_o  = 1'b0;
        instr_addr_o = req_addr_q;
        advance_o    = 1'b0;
        fill         = 1'b0;

        case (state_q)
            FETCH_IDLE: begin
                instr_addr_o = fetch_pc_i;
                if (enable_i && out_free && !flush_i) begin
                    instr_req_o = 1'b1;
                    if (instr_gnt_i) begin
                        advance_o = 1'b1;
                        state_d   = FETCH_WAIT_RVALID;
                    end else begin
                        state_d   = FETCH_WAIT_GNT;
                    end
                end
            end
            FETCH_WAIT_GNT: begin
                instr_req_o = 1'b1;
                if (flush_i) begin
                    killed_d = 1'b1;
                end
                if (instr_gnt_i) begin
                    // A killed request must not move the redirected PC
                    advance_o = !killed_q && !flush_i;
                    state_d   = FETCH_WAIT_RVALID;
                end
            end
            FETCH_WAIT_RVALID: begin
                if (flush_i) begin
                    killed_d = 1'b1;
                end
                if (instr_rvalid_i) begin
                    fill     = !killed_q && !flush_i;
                    killed_d = 1'b0;
                    state_d  = FETCH_IDLE;
                end
            end
            default: state_d = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= FETCH_IDLE;
            killed_q    <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            killed_q <= killed_d;
            if (flush_i) begin
                out_valid_q <= 1'b0;
            end else if (fill) begin
                out_valid_q <= 1'b1;
            end else if (fetch_ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    // Address and data registers
    always_ff @(posedge clk_i) begin
        if (state_q == FETCH_IDLE && instr_req_o) begin
            req_addr_q <= fetch_pc_i;
        end
        if (fill) begin
            out_addr_q  <= req_addr_q;
            out_rdata_q <= instr_rdata_i;
        end
    end

    assign fetch_valid_o = out_valid_q;
    assign fetch_addr_o  = out_addr_q;
    assign fetch_rdata_o = out_rdata_q;

endmodule

`default_nettype wire

// File: src/flush_ctrl.sv
// Redirect arbitration and flush generation
// Priority: debug, exception, exception return, mispredicted branch
// A fence flushes fetch without a redirect, and pulses the icache flush
// one cycle later; all strobes are expected to last a single cycle
`timescale 1ns/10ps
`default_nettype none

module flush_ctrl import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      debug_set_pc_i,
    input  logic      ex_valid_i,
    input  logic      eret_i,
    input  logic      branch_resolve_i,
    input  logic      branch_mispredict_i,
    input  logic      fence_i_i,
    output redirect_e redirect_o,
    output logic      flush_o,
    output logic      flush_icache_o
);

    logic flush_icache_q;

    // Pick the cause, highest priority first
    always_comb begin
        if (debug_set_pc_i) begin
            redirect_o = REDIR_DEBUG;
        end else if (ex_valid_i) begin
            redirect_o = REDIR_TRAP;
        end else if (eret_i) begin
            redirect_o = REDIR_ERET;
        end else if (branch_resolve_i && branch_mispredict_i) begin
            redirect_o = REDIR_BRANCH;
        end else begin
            redirect_o = REDIR_NONE;
        end
    end

    // Any redirect or a fence discards fetched words
    assign flush_o = (redirect_o != REDIR_NONE) || fence_i_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            flush_icache_q <= 1'b0;
        end else begin
            flush_icache_q <= fence_i_i;
        end
    end

    assign flush_icache_o = flush_icache_q;

endmodule

`default_nettype wire

// File: src/frontend_top.sv
// Instruction front end: PC generation, fetch, redirect control, trap CSRs
// fetch_enable_i is registered and acts one cycle late
// All redirect, exception and fence inputs are single-cycle strobes
// boot_addr_i is sampled while reset is low
`timescale 1ns/10ps
`default_nettype none

module frontend_top import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      fetch_enable_i,
    input  addr_t     boot_addr_i,
    // Branch resolution
    input  logic      branch_resolve_i,
    input  logic      branch_mispredict_i,
    input  addr_t     branch_target_i,
    // Exception entry and return
    input  logic      ex_valid_i,
    input  addr_t     ex_pc_i,
    input  logic      eret_i,
    input  logic      fence_i_i,
    // Debug
    input  logic      debug_set_pc_i,
    input  addr_t     debug_pc_i,
    // CSR port
    input  logic      csr_we_i,
    input  csr_addr_t csr_addr_i,
    input  word_t     csr_wdata_i,
    output word_t     csr_rdata_o,
    // Instruction memory
    output addr_t     instr_addr_o,
    output logic      instr_req_o,
    input  logic      instr_gnt_i,
    input  logic      instr_rvalid_i,
    input  word_t     instr_rdata_i,
    // Fetch output
    output logic      fetch_valid_o,
    output addr_t     fetch_addr_o,
    output word_t     fetch_rdata_o,
    input  logic      fetch_ready_i,
    output logic      flush_icache_o
);

    logic      fetch_enable_q;
    addr_t     trap_vec;
    addr_t     epc;
    redirect_e redirect_cause;
    logic      flush;
    addr_t     fetch_pc;
    logic      pc_advance;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fetch_enable_q <= 1'b0;
        end else begin
            fetch_enable_q <= fetch_enable_i;
        end
    end

    // ----------------------------------------
    // Blocks
    // ----------------------------------------
    trap_csr i_trap_csr (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .csr_we_i    (csr_we_i),
        .csr_addr_i  (csr_addr_i),
        .csr_wdata_i (csr_wdata_i),
        .csr_rdata_o (csr_rdata_o),
        .ex_valid_i  (ex_valid_i),
        .ex_pc_i     (ex_pc_i),
        .trap_vec_o  (trap_vec),
        .epc_o       (epc)
    );

    flush_ctrl i_flush_ctrl (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .debug_set_pc_i      (debug_set_pc_i),
        .ex_valid_i          (ex_valid_i),
        .eret_i              (eret_i),
        .branch_resolve_i    (branch_resolve_i),
        .branch_mispredict_i (branch_mispredict_i),
        .fence_i_i           (fence_i_i),
        .redirect_o          (redirect_cause),
        .flush_o             (flush),
        .flush_icache_o      (flush_icache_o)
    );

    pc_gen i_pc_gen (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .boot_addr_i     (boot_addr_i),
        .redirect_i      (redirect_cause),
        .debug_pc_i      (debug_pc_i),
        .branch_target_i (branch_target_i),
        .trap_vec_i      (trap_vec),
        .epc_i           (epc),
        .advance_i       (pc_advance),
        .fetch_pc_o      (fetch_pc)
    );

    fetch_unit i_fetch_unit (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .enable_i       (fetch_enable_q),
        .flush_i        (flush),
        .fetch_pc_i     (fetch_pc),
        .advance_o      (pc_advance),
        .instr_req_o    (instr_req_o),
        .instr_addr_o   (instr_addr_o),
        .instr_gnt_i    (instr_gnt_i),
        .instr_rvalid_i (instr_rvalid_i),
        .instr_rdata_i  (instr_rdata_i),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_addr_o   (fetch_addr_o),
        .fetch_rdata_o  (fetch_rdata_o),
        .fetch_ready_i  (fetch_ready_i)
    );

endmodule

`default_nettype wire

// File: src/pc_gen.sv
// Fetch PC register
// Starts at boot_addr_i, which must be stable while reset is applied
// Steps by one word per granted request; a redirect wins over a step
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module pc_gen import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  addr_t     boot_addr_i,
    input  redirect_e redirect_i,
    // Redirect targets
    input  addr_t     debug_pc_i,
    input  addr_t     branch_target_i,
    input  addr_t     trap_vec_i,
    input  addr_t     epc_i,
    // Step request from the fetch unit
    input  logic      advance_i,
    output addr_t     fetch_pc_o
);

    addr_t pc_q;
    addr_t pc_d;

    // ----------------------------------------
    // Next PC
    // ----------------------------------------
    always_comb begin
        case (redirect_i)
            REDIR_DEBUG:  pc_d = debug_pc_i;
            REDIR_TRAP:   pc_d = trap_vec_i;
            REDIR_ERET:   pc_d = epc_i;
            REDIR_BRANCH: pc_d = branch_target_i;
            default: begin
                if (advance_i) begin
                    pc_d = pc_q + addr_t'(`PC_STEP);
                end else begin
                    pc_d = pc_q;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= boot_addr_i;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign fetch_pc_o = pc_q;

endmodule

`default_nettype wire

// File: src/trap_csr.sv
// Machine trap CSRs: mtvec and mepc
// A CSR write lands on the next clock edge, reads are combinational
// An exception loads mepc and overrides a CSR write to mepc in the same cycle
// mtvec is kept 4-byte aligned; unknown addresses read as 0
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module trap_csr import core_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    // CSR access port
    input  logic      csr_we_i,
    input  csr_addr_t csr_addr_i,
    input  word_t     csr_wdata_i,
    output word_t     csr_rdata_o,
    // Exception entry
    input  logic      ex_valid_i,
    input  addr_t     ex_pc_i,
    // To the PC logic
    output addr_t     trap_vec_o,
    output addr_t     epc_o
);

    addr_t mtvec_q;
    addr_t mepc_q;

    // ----------------------------------------
    // Register update
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtvec_q <= `TRAP_VEC_RESET;
            mepc_q  <= '0;
        end else begin
            if (csr_we_i && csr_addr_i == `CSR_MTVEC) begin
                // Vector base is word aligned, mode bits unsupported
                mtvec_q <= {csr_wdata_i[`XLEN-1:2], 2'b00};
            end
            if (ex_valid_i) begin
                mepc_q <= ex_pc_i;
            end else if (csr_we_i && csr_addr_i == `CSR_MEPC) begin
                mepc_q <= csr_wdata_i;
            end
        end
    end

    // ----------------------------------------
    // Read mux
    // ----------------------------------------
    always_comb begin
        case (csr_addr_i)
            `CSR_MTVEC: csr_rdata_o = mtvec_q;
            `CSR_MEPC:  csr_rdata_o = mepc_q;
            default:    csr_rdata_o = '0;
        endcase
    end

    assign trap_vec_o = mtvec_q;
    assign epc_o      = mepc_q;

endmodule

`default_nettype wire

// File: verification/tb_frontend_model.svh
// Reference model of the front end for tb_frontend
// Tracks the next expected fetch address, mtvec and mepc
// Assumes fences are only issued while no request is in flight
localparam word_t DATA_KEY = 64'h5a5a_c3c3_0f0f_9696;

addr_t       exp_addr;
addr_t       last_addr;
addr_t       m_mtvec;
addr_t       m_mepc;
logic        fence_q;
logic        hold_q;
addr_t       held_addr;
word_t       held_data;
int unsigned delivered;
int unsigned err_count;
int unsigned check_count;

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    check_count++;
    if (got !== exp) begin
        $display("Fail t=%0t %s: got %h expected %h", $time, name, got, exp);
        err_count++;
    end
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
        $display("Fail t=%0t %s: got %h expected %h", $time, name, got, exp);
        err_count++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        $display("Fail t=%0t %s: got %b expected %b", $time, name, got, exp);
        err_count++;
    end
endtask

function automatic word_t csr_read_model(input csr_addr_t addr);
    if (addr == `CSR_MTVEC) begin
        return m_mtvec;
    end else if (addr == `CSR_MEPC) begin
        return m_mepc;
    end
    return '0;
endfunction

task automatic reset_model(input addr_t boot);
    exp_addr  = boot;
    last_addr = '0;
    m_mtvec   = `TRAP_VEC_RESET;
    m_mepc    = '0;
    fence_q   = 1'b0;
    hold_q    = 1'b0;
endtask

// ----------------------------------------
// Model update and checks for one clock edge
// ----------------------------------------
task automatic monitor_cycle;
    logic  redirect;
    logic  flush;
    addr_t target;
    redirect = 1'b1;
    target   = '0;
    if (debug_set_pc_i) begin
        target = debug_pc_i;
    end else if (ex_valid_i) begin
        target = m_mtvec;
    end else if (eret_i) begin
        target = m_mepc;
    end else if (branch_resolve_i && branch_mispredict_i) begin
        target = branch_target_i;
    end else begin
        redirect = 1'b0;
    end
    flush = redirect || fence_i_i;

    check_word("csr_rdata_o", csr_rdata_o, csr_read_model(csr_addr_i));
    check_bit("flush_icache_o", flush_icache_o, fence_q);
    fence_q = fence_i_i;

    // Held entry must not move and must block new requests
    if (fetch_valid_o && !fetch_ready_i) begin
        check_bit("instr_req_o", instr_req_o, 1'b0);
    end
    if (hold_q) begin
        check_bit("fetch_valid_o", fetch_valid_o, 1'b1);
        check_addr("fetch_addr_o", fetch_addr_o, held_addr);
        check_word("fetch_rdata_o", fetch_rdata_o, held_data);
    end
    hold_q    = fetch_valid_o && !fetch_ready_i && !flush;
    held_addr = fetch_addr_o;
    held_data = fetch_rdata_o;

    if (fetch_valid_o && fetch_ready_i && !flush) begin
        check_addr("fetch_addr_o", fetch_addr_o, exp_addr);
        check_word("fetch_rdata_o", fetch_rdata_o, exp_addr ^ DATA_KEY);
        last_addr = fetch_addr_o;
        exp_addr  = exp_addr + `PC_STEP;
        delivered++;
    end
    if (redirect) begin
        exp_addr = target;
    end

    if (csr_we_i && csr_addr_i == `CSR_MTVEC) begin
        m_mtvec = {csr_wdata_i[63:2], 2'b00};
    end
    if (ex_valid_i) begin
        m_mepc = ex_pc_i;
    end else if (csr_we_i && csr_addr_i == `CSR_MEPC) begin
        m_mepc = csr_wdata_i;
    end
endtask

// File: verification/tb_frontend.sv
// Testbench for frontend_top with a randomized memory responder
// Inputs change on falling edges, results are sampled 1 ns before the rising edge
// Memory grants after 0 to 3 cycles and answers 1 to 4 cycles after the grant
`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module tb_frontend import core_pkg::*; ();

    localparam int unsigned LIMIT = 200;
    localparam addr_t BOOT = 64'h8000_0000;

    logic      clk_i;
    logic      rst_ni;
    logic      fetch_enable_i;
    addr_t     boot_addr_i;
    logic      branch_resolve_i;
    logic      branch_mispredict_i;
    addr_t     branch_target_i;
    logic      ex_valid_i;
    addr_t     ex_pc_i;
    logic      eret_i;
    logic      fence_i_i;
    logic      debug_set_pc_i;
    addr_t     debug_pc_i;
    logic      csr_we_i;
    csr_addr_t csr_addr_i;
    word_t     csr_wdata_i;
    word_t     csr_rdata_o;
    addr_t     instr_addr_o;
    logic      instr_req_o;
    logic      instr_gnt_i;
    logic      instr_rvalid_i;
    word_t     instr_rdata_i;
    logic      fetch_valid_o;
    addr_t     fetch_addr_o;
    word_t     fetch_rdata_o;
    logic      fetch_ready_i;
    logic      flush_icache_o;

    // Memory responder state
    logic        pend;
    addr_t       pend_addr;
    int unsigned rv_cnt;
    int unsigned gnt_cnt;
    int unsigned test_base;
    int unsigned tests_run;

    `include "tb_frontend_model.svh"

    frontend_top dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic addr_t rand_addr();
        return {$urandom, $urandom} & ~64'h7;
    endfunction

    // ----------------------------------------
    // Memory responder
    // ----------------------------------------
    task automatic drive_memory;
        instr_rvalid_i = 1'b0;
        if (pend) begin
            if (rv_cnt == 0) begin
                instr_rvalid_i = 1'b1;
                instr_rdata_i  = pend_addr ^ DATA_KEY;
                pend           = 1'b0;
            end else begin
                rv_cnt--;
            end
        end
        instr_gnt_i = !pend && gnt_cnt == 0;
    endtask

    task automatic track_memory;
        if (instr_req_o && instr_gnt_i) begin
            pend      = 1'b1;
            pend_addr = instr_addr_o;
            rv_cnt    = $urandom % 4;
            gnt_cnt   = $urandom % 4;
        end else if (instr_req_o && gnt_cnt > 0) begin
            gnt_cnt--;
        end
    endtask

    // Called at a falling edge, returns at the next one
    task automatic step;
        drive_memory();
        #4;
        if (rst_ni) begin
            monitor_cycle();
            track_memory();
        end
        @(negedge clk_i);
        debug_set_pc_i      = 1'b0;
        ex_valid_i          = 1'b0;
        eret_i              = 1'b0;
        branch_resolve_i    = 1'b0;
        branch_mispredict_i = 1'b0;
        fence_i_i           = 1'b0;
        csr_we_i            = 1'b0;
    endtask

    task automatic wait_deliveries(input int unsigned n, input string what);
        int unsigned goal;
        int unsigned cycles;
        goal   = delivered + n;
        cycles = 0;
        while (delivered < goal && cycles < LIMIT) begin
            step();
            cycles++;
        end
        if (delivered < goal) begin
            $display("Timeout: no fetched word arrived while waiting for %s", what);
            err_count++;
        end
    endtask

    task automatic write_csr(input csr_addr_t addr, input word_t data);
        csr_we_i    = 1'b1;
        csr_addr_i  = addr;
        csr_wdata_i = data;
        step();
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %s, %0d errors", num, name,
                 (err_count == test_base) ? "passed" : "failed", err_count - test_base);
        test_base = err_count;
        tests_run++;
    endtask

    initial begin
        int unsigned r;
        int unsigned idle;
        int unsigned cycles;
        word_t       wval;
        addr_t       saved;
        void'($urandom(47));
        rst_ni = 1'b0;
        fetch_enable_i = 1'b0;
        boot_addr_i = BOOT;
        branch_resolve_i = 1'b0;
        branch_mispredict_i = 1'b0;
        branch_target_i = '0;
        ex_valid_i = 1'b0;
        ex_pc_i = '0;
        eret_i = 1'b0;
        fence_i_i = 1'b0;
        debug_set_pc_i = 1'b0;
        debug_pc_i = '0;
        csr_we_i = 1'b0;
        csr_addr_i = '0;
        csr_wdata_i = '0;
        instr_gnt_i = 1'b0;
        instr_rvalid_i = 1'b0;
        instr_rdata_i = '0;
        fetch_ready_i = 1'b1;
        pend = 1'b0;
        pend_addr = '0;
        rv_cnt = 0;
        gnt_cnt = 0;
        delivered = 0;
        err_count = 0;
        check_count = 0;
        test_base = 0;
        tests_run = 0;
        reset_model(BOOT);

        repeat (8) @(negedge clk_i);
        check_bit("fetch_valid_o", fetch_valid_o, 1'b0);
        check_bit("instr_req_o", instr_req_o, 1'b0);
        check_bit("flush_icache_o", flush_icache_o, 1'b0);
        check_addr("instr_addr_o", instr_addr_o, BOOT);
        rst_ni = 1'b1;

        // 1: sequential fetch from the boot address
        fetch_enable_i = 1'b1;
        wait_deliveries(16, "sequential fetch");
        end_test(1, "sequential fetch");

        // 2: CSR read back
        wval = {$urandom, $urandom} | 64'h3;
        write_csr(`CSR_MTVEC, wval);
        check_word("mtvec readback", csr_rdata_o, wval & ~64'h3);
        wval = {$urandom, $urandom};
        write_csr(`CSR_MEPC, wval);
        check_word("mepc readback", csr_rdata_o, wval);
        csr_addr_i = 12'h300;
        step();
        check_word("unmapped csr", csr_rdata_o, '0);
        end_test(2, "csr access");

        // 3: random redirects, CSR writes and back-pressure
        for (int i = 0; i < 600; i++) begin
            r = $urandom % 32;
            fetch_ready_i   = ($urandom % 4) != 0;
            debug_pc_i      = rand_addr();
            branch_target_i = rand_addr();
            ex_pc_i         = rand_addr();
            csr_wdata_i     = {$urandom, $urandom};
            case ($urandom % 3)
                0: csr_addr_i = `CSR_MTVEC;
                1: csr_addr_i = `CSR_MEPC;
                default: csr_addr_i = 12'h7c0;
            endcase
            case (r)
                0: debug_set_pc_i = 1'b1;
                1: ex_valid_i = 1'b1;
                2: eret_i = 1'b1;
                3: begin
                    branch_resolve_i    = 1'b1;
                    branch_mispredict_i = 1'b1;
                end
                4: branch_resolve_i = 1'b1;
                5: begin
                    debug_set_pc_i      = 1'b1;
                    ex_valid_i          = 1'b1;
                    eret_i              = 1'b1;
                    branch_resolve_i    = 1'b1;
                    branch_mispredict_i = 1'b1;
                end
                6: begin
                    ex_valid_i = 1'b1;
                    eret_i     = 1'b1;
                end
                7: csr_we_i = 1'b1;
                default: ;
            endcase
            step();
        end
        fetch_ready_i = 1'b1;
        wait_deliveries(4, "fetch after random redirects");
        end_test(3, "redirects");

        // 4: exception saves the PC, return fetches from it
        saved      = rand_addr();
        ex_pc_i    = saved;
        ex_valid_i = 1'b1;
        step();
        csr_addr_i = `CSR_MEPC;
        step();
        check_word("mepc after exception", csr_rdata_o, saved);
        eret_i = 1'b1;
        step();
        wait_deliveries(1, "fetch after exception return");
        check_addr("first address after eret", last_addr, saved);
        end_test(4, "exception save");

        // 5: back-pressure holds the entry
        fetch_ready_i = 1'b0;
        cycles = 0;
        while (!fetch_valid_o && cycles < LIMIT) begin
            step();
            cycles++;
        end
        if (!fetch_valid_o) begin
            $display("Timeout: fetch output never became valid under back-pressure");
            err_count++;
        end
        repeat (20) step();
        fetch_ready_i = 1'b1;
        wait_deliveries(8, "fetch after back-pressure");
        end_test(5, "back-pressure");

        // 6: fence once the front end has drained
        fetch_enable_i = 1'b0;
        idle = 0;
        cycles = 0;
        while (idle < 3 && cycles < LIMIT) begin
            step();
            cycles++;
            idle = (!pend && !instr_req_o && !fetch_valid_o) ? idle + 1 : 0;
        end
        if (idle < 3) begin
            $display("Timeout: front end did not drain before the fence");
            err_count++;
        end
        saved     = last_addr + `PC_STEP;
        fence_i_i = 1'b1;
        step();
        check_bit("flush_icache_o pulse", flush_icache_o, 1'b1);
        fetch_enable_i = 1'b1;
        wait_deliveries(1, "fetch after fence");
        check_addr("first address after fence", last_addr, saved);
        end_test(6, "fence");

        $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
